// ==== source/vdp_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_fifo import vdp_pkg::*;
	(
	input wire MCLK,
	input wire rst_n_i,
	input wire cmd_req_i,
	input vdp_op_e cmd_op_i,
	input wire [VRAM_ADDR_W-1:0] cmd_addr_i,
	input wire [DATA_W-1:0] cmd_data_i,
	input wire seq_ack_i,
	output logic cmd_ack_o,
	output logic seq_req_o,
	output vdp_op_e seq_op_o,
	output logic [VRAM_ADDR_W-1:0] seq_addr_o,
	output logic [DATA_W-1:0] seq_data_o
	);

	typedef enum logic {PUSH_IDLE, PUSH_ACK} push_state_e;
	typedef enum logic [1:0] {POP_IDLE, POP_REQ, POP_WAIT} pop_state_e;

	push_state_e push_q;
	pop_state_e pop_q;

	vdp_op_e mem_op [FIFO_DEPTH];
	logic [VRAM_ADDR_W-1:0] mem_addr [FIFO_DEPTH];
	logic [DATA_W-1:0] mem_data [FIFO_DEPTH];

	logic [FIFO_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
	logic [FIFO_PTR_W:0] count_q;
	logic full, empty;
	logic push, pop;

	assign full = (count_q == (FIFO_PTR_W+1)'(FIFO_DEPTH));
	assign empty = (count_q == '0);

	// store on a fresh request, pop when the sequencer took the head
	assign push = (push_q == PUSH_IDLE) & cmd_req_i & ~full;
	assign pop = (pop_q == POP_REQ) & seq_ack_i;

	always_ff @(posedge MCLK)
	begin
		if (push)
		begin
			mem_op[wr_ptr_q] <= cmd_op_i;
			mem_addr[wr_ptr_q] <= cmd_addr_i;
			mem_data[wr_ptr_q] <= cmd_data_i;
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			push_q <= PUSH_IDLE;
			pop_q <= POP_IDLE;
		end
		else
		begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (push & ~pop)
				count_q <= count_q + 1'b1;
			else if (pop & ~push)
				count_q <= count_q - 1'b1;

			case (push_q)
				PUSH_IDLE: if (push) push_q <= PUSH_ACK;
				PUSH_ACK: if (!cmd_req_i) push_q <= PUSH_IDLE;
				default: push_q <= PUSH_IDLE;
			endcase

			case (pop_q)
				POP_IDLE: if (!empty) pop_q <= POP_REQ;
				POP_REQ: if (seq_ack_i) pop_q <= POP_WAIT;
				POP_WAIT: if (!seq_ack_i) pop_q <= POP_IDLE;
				default: pop_q <= POP_IDLE;
			endcase
		end
	end

	assign cmd_ack_o = (push_q == PUSH_ACK);
	assign seq_req_o = (pop_q == POP_REQ);

	// head entry
	assign seq_op_o = mem_op[rd_ptr_q];
	assign seq_addr_o = mem_addr[rd_ptr_q];
	assign seq_data_o = mem_data[rd_ptr_q];

	// count never passes the depth and agrees with the pointers
	a_no_push_full: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		count_q <= (FIFO_PTR_W+1)'(FIFO_DEPTH)
			&& ((full || empty) == (wr_ptr_q == rd_ptr_q)));

	a_no_pop_empty: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		pop |-> !empty);

endmodule

`default_nettype wire

// ==== source/vdp_cpu_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_cpu_port import vdp_pkg::*;
	(
	input wire MCLK,
	input wire rst_n_i,
	input wire cpu_strobe_i,
	input wire cpu_wr_i,
	input wire cpu_port_i,
	input wire [DATA_W-1:0] cpu_data_i,
	input wire cmd_ack_i,
	input wire rd_valid_i,
	input wire [DATA_W-1:0] rd_data_i,
	output logic [DATA_W-1:0] cpu_data_o,
	output logic cpu_wait_o,
	output logic cmd_req_o,
	output vdp_op_e cmd_op_o,
	output logic [VRAM_ADDR_W-1:0] cmd_addr_o,
	output logic [DATA_W-1:0] cmd_data_o,
	output logic disp_en_o,
	output logic [NAME_BASE_W-1:0] name_base_o
	);

	typedef enum logic [1:0]
	{
		HS_IDLE,
		HS_REQ,
		HS_DROP
	} hs_state_e;

	hs_state_e hs_q;

	logic toggle_q;
	logic [DATA_W-1:0] addr_lo_q;
	logic [VRAM_ADDR_W-1:0] addr_q;
	vdp_code_e code_q;
	logic [DATA_W-1:0] rd_buf_q;
	logic rd_pend_q;
	logic [DATA_W-1:0] regs_q [REG_COUNT];

	logic ctrl_wr, ctrl_rd, data_wr, data_rd;
	logic second_byte;
	vdp_code_e code_in;
	logic [VRAM_ADDR_W-1:0] new_addr;
	logic [REG_IDX_W-1:0] reg_idx;
	logic reg_we;
	logic prefetch_ctrl;
	logic issue;

	//////////////////////////////
	// access decode
	//////////////////////////////

	assign ctrl_wr = cpu_strobe_i & cpu_port_i & cpu_wr_i;
	assign ctrl_rd = cpu_strobe_i & cpu_port_i & ~cpu_wr_i;
	assign data_wr = cpu_strobe_i & ~cpu_port_i & cpu_wr_i;
	assign data_rd = cpu_strobe_i & ~cpu_port_i & ~cpu_wr_i;

	assign second_byte = ctrl_wr & toggle_q;
	assign code_in = vdp_code_e'(cpu_data_i[7:6]);
	assign new_addr = {cpu_data_i[VRAM_ADDR_W-DATA_W-1:0], addr_lo_q};
	// address bits 11:8
	assign reg_idx = cpu_data_i[REG_IDX_W-1:0];

	always_comb
	begin
		reg_we = 1'b0;
		prefetch_ctrl = 1'b0;
		if (second_byte)
		begin
			case (code_in)
				CODE_VRAM_READ: prefetch_ctrl = 1'b1;
				CODE_REG_WRITE: reg_we = (reg_idx < REG_IDX_W'(REG_COUNT));
				// no colour ram, both are plain write setup
				CODE_VRAM_WRITE, CODE_CRAM_WRITE: reg_we = 1'b0;
				default: reg_we = 1'b0;
			endcase
		end
	end

	assign issue = prefetch_ctrl | data_wr | data_rd;

	//////////////////////////////
	// address, code, read buffer
	//////////////////////////////

	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
		begin
			toggle_q <= 1'b0;
			addr_lo_q <= '0;
			addr_q <= '0;
			code_q <= CODE_VRAM_READ;
			rd_buf_q <= '0;
			rd_pend_q <= 1'b0;
		end
		else
		begin
			if (rd_valid_i)
			begin
				rd_buf_q <= rd_data_i;
				rd_pend_q <= 1'b0;
			end
			if (ctrl_wr & ~toggle_q)
			begin
				addr_lo_q <= cpu_data_i;
				toggle_q <= 1'b1;
			end
			if (second_byte)
			begin
				code_q <= code_in;
				toggle_q <= 1'b0;
				addr_q <= prefetch_ctrl ? new_addr + 1'b1 : new_addr;
			end
			if (ctrl_rd)
				toggle_q <= 1'b0;
			if (data_wr | data_rd)
			begin
				toggle_q <= 1'b0;
				addr_q <= addr_q + 1'b1;
			end
			if (data_wr)
				rd_buf_q <= cpu_data_i;
			if (prefetch_ctrl | data_rd)
				rd_pend_q <= 1'b1;
		end
	end

	// no status register, a control read echoes the last code
	always_ff @(posedge MCLK)
	begin
		if (data_rd)
			cpu_data_o <= rd_buf_q;
		else if (ctrl_rd)
			cpu_data_o <= {code_q, {(DATA_W-2){1'b0}}};
	end

	// register bank
	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < REG_COUNT; i++)
				regs_q[i] <= '0;
		end
		else if (reg_we)
			regs_q[reg_idx] <= addr_lo_q;
	end

	assign disp_en_o = regs_q[REG_MODE2][DISP_EN_BIT];
	assign name_base_o = regs_q[REG_NAME_BASE][NAME_BASE_W-1:0];

	//////////////////////////////
	// request handshake
	//////////////////////////////

	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
			hs_q <= HS_IDLE;
		else
		begin
			case (hs_q)
				HS_IDLE: if (issue) hs_q <= HS_REQ;
				HS_REQ: if (cmd_ack_i) hs_q <= HS_DROP;
				HS_DROP: if (!cmd_ack_i) hs_q <= HS_IDLE;
				default: hs_q <= HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (issue)
		begin
			cmd_op_o <= data_wr ? OP_WRITE : OP_READ;
			cmd_addr_o <= prefetch_ctrl ? new_addr : addr_q;
			cmd_data_o <= cpu_data_i;
		end
	end

	assign cmd_req_o = (hs_q == HS_REQ);
	assign cpu_wait_o = (hs_q != HS_IDLE) | rd_pend_q;

	a_no_strobe_in_wait: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		cpu_wait_o |-> !cpu_strobe_i);

	a_req_held: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		cmd_req_o && !cmd_ack_i |=> cmd_req_o && $stable(cmd_addr_o) && $stable(cmd_data_o));

endmodule

`default_nettype wire

// ==== source/vdp_pkg.sv ====
`default_nettype none

package vdp_pkg;

	//////////////////////////////
	// bus widths
	//////////////////////////////

	localparam int VRAM_ADDR_W = 14;
	localparam int DATA_W = 8;

	// command buffer
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = 2;

	// strobe length of one vram cycle
	localparam int VRAM_ACCESS_CYCLES = 3;

	//////////////////////////////
	// display registers
	//////////////////////////////

	localparam int REG_COUNT = 11;
	localparam int REG_IDX_W = 4;

	localparam int REG_MODE2 = 1;
	localparam int DISP_EN_BIT = 6;

	localparam int REG_NAME_BASE = 2;
	localparam int NAME_BASE_W = 4;

	// code field of the second control byte
	typedef enum logic [1:0]
	{
		CODE_VRAM_READ  = 2'd0,
		CODE_VRAM_WRITE = 2'd1,
		CODE_REG_WRITE  = 2'd2,
		CODE_CRAM_WRITE = 2'd3
	} vdp_code_e;

	// buffer opcode
	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} vdp_op_e;

endpackage

`default_nettype wire

// ==== source/vdp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_top import vdp_pkg::*;
	(
	input wire MCLK,
	input wire rst_n_i,
	input wire cpu_strobe_i,
	input wire cpu_wr_i,
	input wire cpu_port_i,
	input wire [DATA_W-1:0] cpu_data_i,
	input wire [DATA_W-1:0] vram_data_i,
	output logic [DATA_W-1:0] cpu_data_o,
	output logic cpu_wait_o,
	output logic disp_en_o,
	output logic [NAME_BASE_W-1:0] name_base_o,
	output logic [VRAM_ADDR_W-1:0] vram_addr_o,
	output logic [DATA_W-1:0] vram_data_o,
	output logic vram_we_o,
	output logic vram_oe_o
	);

	//////////////////////////////
	// port to buffer
	//////////////////////////////

	logic cmd_req;
	logic cmd_ack;
	vdp_op_e cmd_op;
	logic [VRAM_ADDR_W-1:0] cmd_addr;
	logic [DATA_W-1:0] cmd_data;

	// buffer to sequencer
	logic seq_req;
	logic seq_ack;
	vdp_op_e seq_op;
	logic [VRAM_ADDR_W-1:0] seq_addr;
	logic [DATA_W-1:0] seq_data;

	// read return
	logic rd_valid;
	logic [DATA_W-1:0] rd_data;

	vdp_cpu_port u_port
		(
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.cpu_strobe_i(cpu_strobe_i),
		.cpu_wr_i(cpu_wr_i),
		.cpu_port_i(cpu_port_i),
		.cpu_data_i(cpu_data_i),
		.cmd_ack_i(cmd_ack),
		.rd_valid_i(rd_valid),
		.rd_data_i(rd_data),
		.cpu_data_o(cpu_data_o),
		.cpu_wait_o(cpu_wait_o),
		.cmd_req_o(cmd_req),
		.cmd_op_o(cmd_op),
		.cmd_addr_o(cmd_addr),
		.cmd_data_o(cmd_data),
		.disp_en_o(disp_en_o),
		.name_base_o(name_base_o)
		);

	vdp_cmd_fifo u_fifo
		(
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.cmd_req_i(cmd_req),
		.cmd_op_i(cmd_op),
		.cmd_addr_i(cmd_addr),
		.cmd_data_i(cmd_data),
		.seq_ack_i(seq_ack),
		.cmd_ack_o(cmd_ack),
		.seq_req_o(seq_req),
		.seq_op_o(seq_op),
		.seq_addr_o(seq_addr),
		.seq_data_o(seq_data)
		);

	vdp_vram_seq u_seq
		(
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.seq_req_i(seq_req),
		.seq_op_i(seq_op),
		.seq_addr_i(seq_addr),
		.seq_data_i(seq_data),
		.vram_data_i(vram_data_i),
		.seq_ack_o(seq_ack),
		.vram_addr_o(vram_addr_o),
		.vram_data_o(vram_data_o),
		.vram_we_o(vram_we_o),
		.vram_oe_o(vram_oe_o),
		.rd_valid_o(rd_valid),
		.rd_data_o(rd_data)
		);

endmodule

`default_nettype wire

// ==== source/vdp_vram_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_vram_seq import vdp_pkg::*;
	(
	input wire MCLK,
	input wire rst_n_i,
	input wire seq_req_i,
	input vdp_op_e seq_op_i,
	input wire [VRAM_ADDR_W-1:0] seq_addr_i,
	input wire [DATA_W-1:0] seq_data_i,
	input wire [DATA_W-1:0] vram_data_i,
	output logic seq_ack_o,
	output logic [VRAM_ADDR_W-1:0] vram_addr_o,
	output logic [DATA_W-1:0] vram_data_o,
	output logic vram_we_o,
	output logic vram_oe_o,
	output logic rd_valid_o,
	output logic [DATA_W-1:0] rd_data_o
	);

	typedef enum logic [1:0]
	{
		IDLE,
		ACCESS,
		RETURN,
		RELEASE
	} seq_state_e;

	seq_state_e state_q;
	logic [$clog2(VRAM_ACCESS_CYCLES)-1:0] cnt_q;
	logic last_cycle;

	vdp_op_e op_q;
	logic [VRAM_ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] data_q;
	logic [DATA_W-1:0] rd_q;
	logic strobe;

	assign last_cycle = (cnt_q == $bits(cnt_q)'(VRAM_ACCESS_CYCLES - 1));

	//////////////////////////////
	// cycle FSM
	//////////////////////////////

	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
		begin
			state_q <= IDLE;
			cnt_q <= '0;
			seq_ack_o <= 1'b0;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					if (seq_req_i)
					begin
						seq_ack_o <= 1'b1;
						cnt_q <= '0;
						state_q <= ACCESS;
					end
				end
				ACCESS:
				begin
					cnt_q <= cnt_q + 1'b1;
					if (last_cycle)
						state_q <= RETURN;
				end
				RETURN: state_q <= RELEASE;
				RELEASE:
				begin
					// wait for the buffer to drop req
					if (!seq_req_i)
					begin
						seq_ack_o <= 1'b0;
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// entry latched together with ack
	always_ff @(posedge MCLK)
	begin
		if (state_q == IDLE && seq_req_i)
		begin
			op_q <= seq_op_i;
			addr_q <= seq_addr_i;
			data_q <= seq_data_i;
		end
		if (state_q == ACCESS && last_cycle && op_q == OP_READ)
			rd_q <= vram_data_i;
	end

	assign vram_addr_o = addr_q;
	assign vram_data_o = data_q;
	assign vram_we_o = (state_q == ACCESS) & (op_q == OP_WRITE);
	assign vram_oe_o = (state_q == ACCESS) & (op_q == OP_READ);

	assign rd_valid_o = (state_q == RETURN) & (op_q == OP_READ);
	assign rd_data_o = rd_q;

	assign strobe = vram_we_o | vram_oe_o;

	a_we_oe_excl: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		!(vram_we_o && vram_oe_o));

	a_strobe_len: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		$rose(strobe) |-> strobe[*VRAM_ACCESS_CYCLES] ##1 !strobe);

endmodule

`default_nettype wire

// ==== vdp_io.f ====
source/vdp_pkg.sv
source/vdp_cpu_port.sv
source/vdp_cmd_fifo.sv
source/vdp_vram_seq.sv
source/vdp_top.sv
verif/vdp_clk_gen.sv
verif/vdp_vram_model.sv
verif/vdp_tb.sv

// ==== verif/vdp_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_clk_gen
	(
	output logic MCLK,
	output logic rst_n_o
	);

	localparam int RESET_CYCLES = 16;

	// 4 ns period
	initial
	begin
		MCLK = 1'b0;
		forever #2 MCLK = ~MCLK;
	end

	// release on a falling edge, clear of the sampling edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge MCLK);
		@(negedge MCLK);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verif/vdp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_tb import vdp_pkg::*;
	();

	localparam int REG_PAIRS = 14;
	localparam int WR_RUN = 8;
	localparam int BP_RUN = 20;
	localparam int TG_RUN = 4;
	// accesses per test section, in run order
	localparam int ACCESS_COUNT = 2*REG_PAIRS + (4 + 2*WR_RUN) + (8 + 2*WR_RUN)
		+ (4 + 2*BP_RUN) + 2*(4 + TG_RUN);
	localparam int TIMEOUT_CYCLES = ACCESS_COUNT*24 + 16 + 200;

	logic MCLK, rst_n;
	logic cpu_strobe, cpu_wr, cpu_port;
	logic [DATA_W-1:0] cpu_data, cpu_data_out;
	logic cpu_wait, disp_en;
	logic [NAME_BASE_W-1:0] name_base;
	logic [VRAM_ADDR_W-1:0] vram_addr;
	logic [DATA_W-1:0] vram_wdata, vram_rdata;
	logic vram_we, vram_oe;
	int model_errors;

	// shadow of the port state and of vram
	logic [DATA_W-1:0] sh_mem [2**VRAM_ADDR_W];
	logic [DATA_W-1:0] sh_regs [REG_COUNT];
	logic [VRAM_ADDR_W-1:0] sh_addr;
	logic [DATA_W-1:0] sh_lo, sh_rdbuf;
	logic sh_toggle;

	logic [VRAM_ADDR_W-1:0] exp_wr_addr_q [$];
	logic [DATA_W-1:0] exp_wr_data_q [$];
	logic exp_wr_valid;
	logic [VRAM_ADDR_W-1:0] exp_wr_addr;
	logic [DATA_W-1:0] exp_wr_data, exp_rd_data;
	logic exp_disp_en;
	logic [NAME_BASE_W-1:0] exp_name_base;

	integer seed;
	int errors, cycles, wait_run, single_wait, bp_max_wait;
	logic bp_phase, we_seen, rd_access;
	logic [VRAM_ADDR_W-1:0] wr_base, bp_base;

	vdp_clk_gen clk_gen (.MCLK(MCLK), .rst_n_o(rst_n));

	vdp_top UUT
		(
		.MCLK(MCLK),
		.rst_n_i(rst_n),
		.cpu_strobe_i(cpu_strobe),
		.cpu_wr_i(cpu_wr),
		.cpu_port_i(cpu_port),
		.cpu_data_i(cpu_data),
		.vram_data_i(vram_rdata),
		.cpu_data_o(cpu_data_out),
		.cpu_wait_o(cpu_wait),
		.disp_en_o(disp_en),
		.name_base_o(name_base),
		.vram_addr_o(vram_addr),
		.vram_data_o(vram_wdata),
		.vram_we_o(vram_we),
		.vram_oe_o(vram_oe)
		);

	vdp_vram_model vram
		(
		.MCLK(MCLK),
		.rst_n_i(rst_n),
		.vram_addr_i(vram_addr),
		.vram_wdata_i(vram_wdata),
		.vram_we_i(vram_we),
		.vram_oe_i(vram_oe),
		.exp_valid_i(exp_wr_valid),
		.exp_addr_i(exp_wr_addr),
		.exp_data_i(exp_wr_data),
		.vram_rdata_o(vram_rdata),
		.errors_o(model_errors)
		);

	function automatic logic [DATA_W-1:0] preset_byte(input int a);
		preset_byte = DATA_W'(a) ^ DATA_W'(a >> 8) ^ 8'h3c;
	endfunction

	task automatic refresh_expect();
		exp_wr_valid = (exp_wr_addr_q.size() != 0);
		if (exp_wr_valid)
		begin
			exp_wr_addr = exp_wr_addr_q[0];
			exp_wr_data = exp_wr_data_q[0];
		end
	endtask

	//////////////////////////////
	// cpu accesses
	//////////////////////////////

	// one strobe on a falling edge once the port is free
	task automatic cpu_access(input logic port, input logic wr, input logic [DATA_W-1:0] data);
		while (cpu_wait)
			@(negedge MCLK);
		cpu_port = port;
		cpu_wr = wr;
		cpu_data = data;
		cpu_strobe = 1'b1;
		@(negedge MCLK);
		cpu_strobe = 1'b0;
	endtask

	task automatic ctrl_write(input logic [DATA_W-1:0] b);
		cpu_access(1'b1, 1'b1, b);
		if (!sh_toggle)
		begin
			sh_lo = b;
			sh_toggle = 1'b1;
		end
		else
		begin
			sh_toggle = 1'b0;
			sh_addr = {b[5:0], sh_lo};
			if (b[7:6] == CODE_REG_WRITE && b[3:0] < REG_COUNT)
				sh_regs[b[3:0]] = sh_lo;
			// read-ahead of the first byte
			if (b[7:6] == CODE_VRAM_READ)
			begin
				sh_rdbuf = sh_mem[sh_addr];
				sh_addr = sh_addr + 1'b1;
			end
		end
		exp_disp_en = sh_regs[REG_MODE2][DISP_EN_BIT];
		exp_name_base = sh_regs[REG_NAME_BASE][NAME_BASE_W-1:0];
	endtask

	task automatic ctrl_read();
		cpu_access(1'b1, 1'b0, 8'h00);
		sh_toggle = 1'b0;
	endtask

	task automatic data_write(input logic [DATA_W-1:0] d);
		cpu_access(1'b0, 1'b1, d);
		sh_mem[sh_addr] = d;
		exp_wr_addr_q.push_back(sh_addr);
		exp_wr_data_q.push_back(d);
		refresh_expect();
		sh_rdbuf = d;
		sh_addr = sh_addr + 1'b1;
		sh_toggle = 1'b0;
	endtask

	// expected byte held until the next read may strobe
	task automatic data_read();
		while (cpu_wait)
			@(negedge MCLK);
		exp_rd_data = sh_rdbuf;
		cpu_access(1'b0, 1'b0, 8'h00);
		sh_rdbuf = sh_mem[sh_addr];
		sh_addr = sh_addr + 1'b1;
		sh_toggle = 1'b0;
	endtask

	task automatic set_address(input logic [VRAM_ADDR_W-1:0] a, input logic [1:0] code);
		ctrl_write(a[7:0]);
		ctrl_write({code, a[13:8]});
	endtask

	task automatic write_register(input logic [REG_IDX_W-1:0] idx, input logic [DATA_W-1:0] v);
		ctrl_write(v);
		ctrl_write({2'b10, 2'b00, idx});
	endtask

	//////////////////////////////
	// monitors and checks
	//////////////////////////////

	// write order and wait lengths, sampled away from the rising edge
	always @(negedge MCLK)
	begin
		// head retires once its strobe has ended
		if (!vram_we && we_seen && exp_wr_addr_q.size() != 0)
		begin
			exp_wr_addr_q.delete(0);
			exp_wr_data_q.delete(0);
			refresh_expect();
		end
		we_seen = vram_we;
		if (cpu_wait)
			wait_run++;
		else if (wait_run != 0)
		begin
			if (single_wait == 0)
				single_wait = wait_run;
			if (bp_phase && wait_run > bp_max_wait)
				bp_max_wait = wait_run;
			wait_run = 0;
		end
	end

	always @(posedge MCLK)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	assign rd_access = cpu_strobe && !cpu_port && !cpu_wr;

	a_reset_state: assert property (@(posedge MCLK)
		$rose(rst_n) |-> !cpu_wait && !vram_we && !vram_oe && !disp_en && name_base == '0)
	else
	begin
		errors++;
		$display("FAIL %0t: outputs not idle right after reset", $time);
	end

	a_read_data: assert property (@(posedge MCLK) disable iff (!rst_n)
		rd_access |=> cpu_data_out == exp_rd_data)
	else
	begin
		errors++;
		$display("FAIL %0t: data read returned %h, expected %h", $time,
			$sampled(cpu_data_out), $sampled(exp_rd_data));
	end

	a_register_outputs: assert property (@(posedge MCLK) disable iff (!rst_n)
		disp_en == exp_disp_en && name_base == exp_name_base)
	else
	begin
		errors++;
		$display("FAIL %0t: disp_en %b name_base %h, expected %b %h", $time,
			$sampled(disp_en), $sampled(name_base), $sampled(exp_disp_en),
			$sampled(exp_name_base));
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial
	begin
		seed = 32'hd43f788f;
		cpu_strobe = 1'b0;
		cpu_wr = 1'b0;
		cpu_port = 1'b0;
		cpu_data = '0;
		errors = 0;
		cycles = 0;
		wait_run = 0;
		single_wait = 0;
		bp_max_wait = 0;
		bp_phase = 1'b0;
		we_seen = 1'b0;
		sh_addr = '0;
		sh_lo = '0;
		sh_rdbuf = '0;
		sh_toggle = 1'b0;
		exp_rd_data = '0;
		exp_disp_en = 1'b0;
		exp_name_base = '0;
		for (int i = 0; i < REG_COUNT; i++)
			sh_regs[i] = '0;
		for (int i = 0; i < 2**VRAM_ADDR_W; i++)
			sh_mem[i] = preset_byte(i);
		refresh_expect();

		@(posedge rst_n);
		@(negedge MCLK);

		// display registers, including ignored indexes
		write_register(4'd1, 8'h40);
		write_register(4'd2, 8'h0b);
		write_register(4'd0, 8'hff);
		write_register(4'd10, 8'hff);
		write_register(4'd11, 8'h00);
		write_register(4'd15, 8'h00);
		write_register(4'd1, 8'hbf);
		write_register(4'd2, 8'hf3);
		repeat (REG_PAIRS - 8)
			write_register(4'($random(seed)), 8'($random(seed)));

		wr_base = VRAM_ADDR_W'($random(seed));
		set_address(wr_base, CODE_VRAM_WRITE);
		repeat (WR_RUN)
			data_write(8'($random(seed)));
		// code 3 across the top of memory
		set_address(14'h3ffc, CODE_CRAM_WRITE);
		repeat (WR_RUN)
			data_write(8'($random(seed)));

		set_address(wr_base, CODE_VRAM_READ);
		repeat (WR_RUN)
			data_read();
		set_address(14'h3ffc, CODE_VRAM_READ);
		repeat (WR_RUN)
			data_read();
		set_address(wr_base + 14'd100, CODE_VRAM_WRITE);
		data_write(8'($random(seed)));
		data_read();

		// back to back writes until the buffer fills
		bp_base = VRAM_ADDR_W'($random(seed));
		set_address(bp_base, CODE_VRAM_WRITE);
		bp_phase = 1'b1;
		repeat (BP_RUN)
			data_write(8'($random(seed)));
		bp_phase = 1'b0;
		set_address(bp_base, CODE_VRAM_READ);
		repeat (BP_RUN)
			data_read();

		// lone first byte, then a data read
		ctrl_write(8'h5a);
		data_read();
		set_address(VRAM_ADDR_W'($random(seed)), CODE_VRAM_READ);
		repeat (TG_RUN)
			data_read();
		// lone first byte, then a control read
		ctrl_write(8'ha5);
		ctrl_read();
		set_address(VRAM_ADDR_W'($random(seed)), CODE_VRAM_READ);
		repeat (TG_RUN)
			data_read();

		while (exp_wr_addr_q.size() != 0 || cpu_wait)
			@(negedge MCLK);
		repeat (4) @(negedge MCLK);

		assert (bp_max_wait > single_wait)
		else
		begin
			errors++;
			$display("the full buffer never held cpu_wait_o longer than a lone write did");
		end

		$display("errors: %0d testbench, %0d vram model", errors, model_errors);
		if (errors == 0 && model_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/vdp_vram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_vram_model import vdp_pkg::*;
	(
	input wire MCLK,
	input wire rst_n_i,
	input wire [VRAM_ADDR_W-1:0] vram_addr_i,
	input wire [DATA_W-1:0] vram_wdata_i,
	input wire vram_we_i,
	input wire vram_oe_i,
	input wire exp_valid_i,
	input wire [VRAM_ADDR_W-1:0] exp_addr_i,
	input wire [DATA_W-1:0] exp_data_i,
	output logic [DATA_W-1:0] vram_rdata_o,
	output int errors_o
	);

	logic [DATA_W-1:0] mem [2**VRAM_ADDR_W];
	int err_cnt;

	// power-up contents, every address bit shows up in the byte
	function automatic logic [DATA_W-1:0] init_byte(input int a);
		init_byte = DATA_W'(a) ^ DATA_W'(a >> 8) ^ 8'h3c;
	endfunction

	initial
	begin
		err_cnt = 0;
		for (int i = 0; i < 2**VRAM_ADDR_W; i++)
			mem[i] = init_byte(i);
	end

	always @(posedge MCLK)
	begin
		if (vram_we_i)
			mem[vram_addr_i] <= vram_wdata_i;
	end

	// read data stays valid through the whole strobe
	assign vram_rdata_o = vram_oe_i ? mem[vram_addr_i] : '0;
	assign errors_o = err_cnt;

	//////////////////////////////
	// bus protocol
	//////////////////////////////

	a_write_expected: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		$rose(vram_we_i) |-> exp_valid_i && vram_addr_i == exp_addr_i
			&& vram_wdata_i == exp_data_i)
	else
	begin
		err_cnt++;
		$display("FAIL %0t: vram write %h <= %h, expected %h <= %h (pending %0b)", $time,
			$sampled(vram_addr_i), $sampled(vram_wdata_i), $sampled(exp_addr_i),
			$sampled(exp_data_i), $sampled(exp_valid_i));
	end

	a_strobe_excl: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		!(vram_we_i && vram_oe_i))
	else
	begin
		err_cnt++;
		$display("vram write and read strobes were both high at %0t", $time);
	end

	a_bus_stable: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		(vram_we_i || vram_oe_i) ##1 (vram_we_i || vram_oe_i)
			|-> $stable(vram_addr_i) && $stable(vram_wdata_i))
	else
	begin
		err_cnt++;
		$display("vram address or write data moved during a strobe at %0t", $time);
	end

endmodule

`default_nettype wire
